//--- rtl/dm_pkg.sv
package dm_pkg;

  // word and bus data width
  localparam int data_width = 32;

  // memory depth in words
  localparam int mem_words = 4096;

  // word index width, log2 of mem_words
  localparam int mem_addr_width = 12;

  // byte address width on the bus
  localparam int bus_addr_width = 15;

  // address map
  // memory sits at byte 0 up to 16'h3fff
  // registers start right above it
  localparam logic [15:0] reg_base = 16'h4000;

  // register offsets from reg_base
  localparam logic [3:0] reg_ctrl_off   = 4'h0;
  localparam logic [3:0] reg_status_off = 4'h4;
  localparam logic [3:0] reg_rdcnt_off  = 4'h8;
  localparam logic [3:0] reg_wrcnt_off  = 4'hc;

  // AXI response codes
  localparam logic [1:0] resp_okay   = 2'b00;
  localparam logic [1:0] resp_slverr = 2'b10;

  // one memory word, also the bus data
  typedef logic [data_width-1:0] dm_data_t;

  // word index into the array
  typedef logic [mem_addr_width-1:0] dm_word_addr_t;

  // byte address as seen on AW and AR
  typedef logic [bus_addr_width-1:0] dm_bus_addr_t;

  // B and R response
  typedef logic [1:0] dm_resp_t;

endpackage

//--- rtl/dm_store.sv
`timescale 1ns/10ps

module dm_store (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  enable_mem,
  input  logic                  enable_fetch,
  input  logic                  enable_writeback,
  input  logic [3:0]            byte_en,
  input  dm_pkg::dm_word_addr_t addr,
  input  dm_pkg::dm_data_t      din,
  input  logic                  clear_start,
  output dm_pkg::dm_data_t      dout,
  output logic                  clear_busy
);

  import dm_pkg::*;

  // last index touched by the sweep
  localparam dm_word_addr_t last_word = dm_word_addr_t'(mem_words - 1);

  // word array
  dm_data_t mem [mem_words];

  // sweep pointer, one word per cycle
  dm_word_addr_t clr_cnt;

  // sweep control
  // reset and clear_start both restart from word 0
  always_ff @(posedge clk) begin
    if (rst) begin
      clear_busy <= 1'b1;
      clr_cnt    <= '0;
    end else if (clear_start) begin
      clear_busy <= 1'b1;
      clr_cnt    <= '0;
    end else if (clear_busy) begin
      clr_cnt <= clr_cnt + 1'b1;
      // done once the top word is zeroed
      if (clr_cnt == last_word) begin
        clear_busy <= 1'b0;
      end
    end
  end

  // array writes
  // sweep owns the array while busy
  always_ff @(posedge clk) begin
    if (clear_busy) begin
      mem[clr_cnt] <= '0;
    end else if (enable_mem && !enable_fetch && enable_writeback) begin
      // only enabled byte lanes change
      for (int b = 0; b < data_width / 8; b++) begin
        if (byte_en[b]) begin
          mem[addr][b*8 +: 8] <= din[b*8 +: 8];
        end
      end
    end
  end

  // registered read port
  // fetch wins over writeback
  always_ff @(posedge clk) begin
    if (rst) begin
      dout <= '0;
    end else if (enable_mem && enable_fetch) begin
      dout <= mem[addr];
    end
  end

  // the slave must hold memory traffic off during a sweep
  a_no_access_in_clear: assert property (
    @(posedge clk) disable iff (rst)
    clear_busy |-> !enable_mem
  );

  // slave never asks for both directions at once
  a_no_fetch_and_wb: assert property (
    @(posedge clk) disable iff (rst)
    enable_mem |-> !(enable_fetch && enable_writeback)
  );

endmodule

//--- rtl/dm_regs.sv
`timescale 1ns/10ps

module dm_regs (
  input  logic             clk,
  input  logic             rst,
  input  logic             reg_wr,
  input  logic             reg_rd,
  input  logic [1:0]       reg_sel,
  input  dm_pkg::dm_data_t reg_wdata,
  input  logic             mem_rd_done,
  input  logic             mem_wr_done,
  input  logic             clear_busy,
  output dm_pkg::dm_data_t reg_rdata,
  output logic             clear_start
);

  import dm_pkg::*;

  // byte offset of the selected register
  logic [3:0] sel_off;

  // one-hot register selects
  logic sel_ctrl;
  logic sel_status;
  logic sel_rdcnt;
  logic sel_wrcnt;

  // access counters
  dm_data_t rd_cnt;
  dm_data_t wr_cnt;

  assign sel_off    = {reg_sel, 2'b00};
  assign sel_ctrl   = (sel_off == reg_ctrl_off);
  assign sel_status = (sel_off == reg_status_off);
  assign sel_rdcnt  = (sel_off == reg_rdcnt_off);
  assign sel_wrcnt  = (sel_off == reg_wrcnt_off);

  // clear request
  // ctrl bit 0 written as one, dropped while a sweep runs
  // bit is not stored so it reads back zero
  always_ff @(posedge clk) begin
    if (rst) begin
      clear_start <= 1'b0;
    end else begin
      clear_start <= reg_wr && sel_ctrl && reg_wdata[0] && !clear_busy;
    end
  end

  // completed memory reads
  // any write to the register clears it
  always_ff @(posedge clk) begin
    if (rst) begin
      rd_cnt <= '0;
    end else if (reg_wr && sel_rdcnt) begin
      rd_cnt <= '0;
    end else if (mem_rd_done) begin
      // wraps at all ones
      rd_cnt <= rd_cnt + 1'b1;
    end
  end

  // completed memory writes
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_cnt <= '0;
    end else if (reg_wr && sel_wrcnt) begin
      wr_cnt <= '0;
    end else if (mem_wr_done) begin
      wr_cnt <= wr_cnt + 1'b1;
    end
  end

  // read mux, zero unless a read is issued
  always_comb begin
    reg_rdata = '0;
    if (reg_rd) begin
      if (sel_status) begin
        reg_rdata[0] = clear_busy;
      end else if (sel_rdcnt) begin
        reg_rdata = rd_cnt;
      end else if (sel_wrcnt) begin
        reg_rdata = wr_cnt;
      end
      // ctrl reads as zero
    end
  end

  // a start pulse only while the store is idle
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (rst)
    clear_start |-> !clear_busy
  );

  // store answers a start with busy on the next cycle
  a_start_sets_busy: assert property (
    @(posedge clk) disable iff (rst)
    clear_start |=> clear_busy
  );

endmodule

//--- rtl/dm_axil_slave.sv
`timescale 1ns/10ps

module dm_axil_slave (
  input  logic                  clk,
  input  logic                  rst,
  // AW channel
  input  dm_pkg::dm_bus_addr_t  s_awaddr,
  input  logic                  s_awvalid,
  output logic                  s_awready,
  // W channel
  input  dm_pkg::dm_data_t      s_wdata,
  input  logic [3:0]            s_wstrb,
  input  logic                  s_wvalid,
  output logic                  s_wready,
  // B channel
  output dm_pkg::dm_resp_t      s_bresp,
  output logic                  s_bvalid,
  input  logic                  s_bready,
  // AR channel
  input  dm_pkg::dm_bus_addr_t  s_araddr,
  input  logic                  s_arvalid,
  output logic                  s_arready,
  // R channel
  output dm_pkg::dm_data_t      s_rdata,
  output dm_pkg::dm_resp_t      s_rresp,
  output logic                  s_rvalid,
  input  logic                  s_rready,
  // store side
  input  logic                  clear_busy,
  input  dm_pkg::dm_data_t      dout,
  output logic                  enable_mem,
  output logic                  enable_fetch,
  output logic                  enable_writeback,
  output logic [3:0]            byte_en,
  output dm_pkg::dm_word_addr_t addr,
  output dm_pkg::dm_data_t      din,
  // register side
  input  dm_pkg::dm_data_t      reg_rdata,
  output logic                  reg_wr,
  output logic                  reg_rd,
  output logic [1:0]            reg_sel,
  output dm_pkg::dm_data_t      reg_wdata,
  output logic                  mem_rd_done,
  output logic                  mem_wr_done
);

  import dm_pkg::*;

  typedef enum logic [1:0] {
    st_idle,
    st_wresp,
    st_rwait,
    st_rresp
  } state_t;

  state_t state;

  // registered readies, AW and W share one
  logic wr_rdy;
  logic rd_rdy;

  // address decode per channel
  logic wr_is_mem;
  logic wr_is_reg;
  logic rd_is_mem;
  logic rd_is_reg;

  // request may be accepted this cycle
  logic wr_go;
  logic rd_go;

  // handshakes
  logic wr_hs;
  logic rd_hs;

  assign s_awready = wr_rdy;
  assign s_wready  = wr_rdy;
  assign s_arready = rd_rdy;

  // memory below reg_base, 16 bytes of registers above it
  assign wr_is_mem = (s_awaddr < reg_base);
  assign wr_is_reg = !wr_is_mem && (s_awaddr <= reg_base + 16'hf);
  assign rd_is_mem = (s_araddr < reg_base);
  assign rd_is_reg = !rd_is_mem && (s_araddr <= reg_base + 16'hf);

  // memory traffic waits for the sweep, registers and errors do not
  assign wr_go = s_awvalid && s_wvalid && !(wr_is_mem && clear_busy);
  // write wins when both are ready to go
  assign rd_go = s_arvalid && !(rd_is_mem && clear_busy) && !wr_go;

  assign wr_hs = wr_rdy && s_awvalid && s_wvalid;
  assign rd_hs = rd_rdy && s_arvalid;

  // store controls, live only in the handshake cycle
  assign enable_fetch     = rd_hs && rd_is_mem;
  assign enable_writeback = wr_hs && wr_is_mem;
  assign enable_mem       = enable_fetch || enable_writeback;
  assign addr     = rd_hs ? s_araddr[mem_addr_width+1:2] : s_awaddr[mem_addr_width+1:2];
  assign byte_en  = s_wstrb;
  assign din      = s_wdata;

  // register controls, full word only
  assign reg_wr    = wr_hs && wr_is_reg;
  assign reg_rd    = rd_hs && rd_is_reg;
  assign reg_sel   = rd_hs ? s_araddr[3:2] : s_awaddr[3:2];
  assign reg_wdata = s_wdata;

  // counter pulses
  // write lands on the handshake edge, read data in rwait
  assign mem_wr_done = enable_writeback;
  assign mem_rd_done = (state == st_rwait);

  // control FSM
  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_idle;
      wr_rdy   <= 1'b0;
      rd_rdy   <= 1'b0;
      s_bvalid <= 1'b0;
      s_rvalid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (wr_hs) begin
            wr_rdy   <= 1'b0;
            s_bvalid <= 1'b1;
            state    <= st_wresp;
          end else if (rd_hs) begin
            rd_rdy <= 1'b0;
            if (rd_is_mem) begin
              // dout lands this edge, captured next cycle
              state <= st_rwait;
            end else begin
              s_rvalid <= 1'b1;
              state    <= st_rresp;
            end
          end else if (!wr_rdy && !rd_rdy) begin
            // ready one cycle after the valids
            wr_rdy <= wr_go;
            rd_rdy <= rd_go;
          end
        end
        st_wresp: begin
          if (s_bready) begin
            s_bvalid <= 1'b0;
            state    <= st_idle;
          end
        end
        st_rwait: begin
          s_rvalid <= 1'b1;
          state    <= st_rresp;
        end
        st_rresp: begin
          if (s_rready) begin
            s_rvalid <= 1'b0;
            state    <= st_idle;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  // response payload
  always_ff @(posedge clk) begin
    if (state == st_idle && wr_hs) begin
      s_bresp <= (wr_is_mem || wr_is_reg) ? resp_okay : resp_slverr;
    end
    if (state == st_idle && rd_hs && !rd_is_mem) begin
      // unmapped reads return zero
      s_rdata <= rd_is_reg ? reg_rdata : '0;
      s_rresp <= rd_is_reg ? resp_okay : resp_slverr;
    end else if (state == st_rwait) begin
      s_rdata <= dout;
      s_rresp <= resp_okay;
    end
  end

  // B stays put while the master stalls
  a_b_stable: assert property (
    @(posedge clk) disable iff (rst)
    s_bvalid && !s_bready |=> s_bvalid && $stable(s_bresp)
  );

  // R stays put while the master stalls
  a_r_stable: assert property (
    @(posedge clk) disable iff (rst)
    s_rvalid && !s_rready |=> s_rvalid && $stable(s_rdata) && $stable(s_rresp)
  );

endmodule

//--- rtl/dm_subsystem.sv
`timescale 1ns/10ps

module dm_subsystem (
  input  logic                 clk,
  input  logic                 rst,
  input  dm_pkg::dm_bus_addr_t s_awaddr,
  input  logic                 s_awvalid,
  output logic                 s_awready,
  input  dm_pkg::dm_data_t     s_wdata,
  input  logic [3:0]           s_wstrb,
  input  logic                 s_wvalid,
  output logic                 s_wready,
  output dm_pkg::dm_resp_t     s_bresp,
  output logic                 s_bvalid,
  input  logic                 s_bready,
  input  dm_pkg::dm_bus_addr_t s_araddr,
  input  logic                 s_arvalid,
  output logic                 s_arready,
  output dm_pkg::dm_data_t     s_rdata,
  output dm_pkg::dm_resp_t     s_rresp,
  output logic                 s_rvalid,
  input  logic                 s_rready
);

  import dm_pkg::*;

  // slave to store
  logic          enable_mem;
  logic          enable_fetch;
  logic          enable_writeback;
  logic [3:0]    byte_en;
  dm_word_addr_t addr;
  dm_data_t      din;
  dm_data_t      dout;

  // slave to register block
  logic       reg_wr;
  logic       reg_rd;
  logic [1:0] reg_sel;
  dm_data_t   reg_wdata;
  dm_data_t   reg_rdata;
  logic       mem_rd_done;
  logic       mem_wr_done;

  // register block and store
  logic clear_start;
  logic clear_busy;

  // bus front end
  dm_axil_slave dm_axil_slave_inst (.*);

  // control and counters
  dm_regs dm_regs_inst (.*);

  // word array
  dm_store dm_store_inst (.*);

endmodule

//--- include/dm_tb_checks.svh
`ifndef DM_TB_CHECKS_SVH
`define DM_TB_CHECKS_SVH

// data compare where X on either side mismatches
task automatic check_data(input string name, input dm_data_t exp, input dm_data_t act);
  if (act !== exp) begin
    error_count++;
    $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
  end
endtask

// response compare
task automatic check_resp(input string name, input dm_resp_t exp, input dm_resp_t act);
  if (act !== exp) begin
    error_count++;
    $display("FAIL %0t %s expected %h got %h", $time, name, exp, act);
  end
endtask

// single handshake flag compare
task automatic check_flag(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    error_count++;
    $display("FAIL %0t %s expected %b got %b", $time, name, exp, act);
  end
endtask

// bounded wait for a slave flag sampled high on a rising edge
// 0 awready, 1 bvalid, 2 arready, 3 rvalid
task automatic wait_flag(input int which, input string what, output bit seen);
  seen = 1'b0;
  for (int n = 0; n < wait_limit && !seen; n++) begin
    @(posedge clk);
    case (which)
      0: begin
        seen = s_awready;
        // wready rises and falls with awready
        check_flag("s_wready", s_awready, s_wready);
      end
      1: seen = s_bvalid;
      2: seen = s_arready;
      default: seen = s_rvalid;
    endcase
  end
  if (!seen) begin
    timeout_count++;
    $display("timeout at %0t while waiting for %s", $time, what);
  end
endtask

// AW and W raised together with bready held off for bdelay cycles
task automatic axil_write(input dm_bus_addr_t a, input dm_data_t d, input logic [3:0] strb,
                          input int bdelay, output dm_resp_t resp);
  bit seen;
  resp = 2'bxx;
  s_awaddr  <= a;
  s_wdata   <= d;
  s_wstrb   <= strb;
  s_awvalid <= 1'b1;
  s_wvalid  <= 1'b1;
  wait_flag(0, "awready and wready", seen);
  // handshake was on this edge
  s_awvalid <= 1'b0;
  s_wvalid  <= 1'b0;
  if (seen) begin
    wait_flag(1, "bvalid", seen);
  end
  if (seen) begin
    repeat (bdelay) @(posedge clk);
    s_bready <= 1'b1;
    @(posedge clk);
    s_bready <= 1'b0;
    // bvalid must still be up when bready arrives
    check_flag("s_bvalid", 1'b1, s_bvalid);
    // B sampled on its own handshake edge
    resp = s_bresp;
  end
endtask

// AR then R with rready held off for rdelay cycles
task automatic axil_read(input dm_bus_addr_t a, input int rdelay, output dm_resp_t resp,
                         output dm_data_t data);
  bit seen;
  resp = 2'bxx;
  data = 'x;
  s_araddr  <= a;
  s_arvalid <= 1'b1;
  wait_flag(2, "arready", seen);
  s_arvalid <= 1'b0;
  if (seen) begin
    wait_flag(3, "rvalid", seen);
  end
  if (seen) begin
    repeat (rdelay) @(posedge clk);
    s_rready <= 1'b1;
    @(posedge clk);
    s_rready <= 1'b0;
    // rvalid held through the stall
    check_flag("s_rvalid", 1'b1, s_rvalid);
    resp = s_rresp;
    data = s_rdata;
  end
endtask

`endif

//--- test/dm_subsystem_tb.sv
`timescale 1ns/10ps

module dm_subsystem_tb;

  import dm_pkg::*;

  // long enough to sit out a full sweep
  localparam int wait_limit = 10000;
  // status polls, each one a few cycles
  localparam int poll_limit = 2000;

  localparam dm_bus_addr_t ctrl_addr   = dm_bus_addr_t'(reg_base + reg_ctrl_off);
  localparam dm_bus_addr_t status_addr = dm_bus_addr_t'(reg_base + reg_status_off);
  localparam dm_bus_addr_t rdcnt_addr  = dm_bus_addr_t'(reg_base + reg_rdcnt_off);
  localparam dm_bus_addr_t wrcnt_addr  = dm_bus_addr_t'(reg_base + reg_wrcnt_off);

  logic         clk;
  logic         rst;
  dm_bus_addr_t s_awaddr;
  logic         s_awvalid;
  logic         s_awready;
  dm_data_t     s_wdata;
  logic [3:0]   s_wstrb;
  logic         s_wvalid;
  logic         s_wready;
  dm_resp_t     s_bresp;
  logic         s_bvalid;
  logic         s_bready;
  dm_bus_addr_t s_araddr;
  logic         s_arvalid;
  logic         s_arready;
  dm_data_t     s_rdata;
  dm_resp_t     s_rresp;
  logic         s_rvalid;
  logic         s_rready;

  int            error_count;
  int            timeout_count;
  logic [31:0]   lfsr_state;
  // expected memory contents
  dm_data_t      model [mem_words];
  // expected counter values
  int            exp_rd;
  int            exp_wr;
  // word indices written in the write/read test
  dm_word_addr_t used [16];

  dm_subsystem dm_subsystem_inst (.*);

  `include "dm_tb_checks.svh"

  // galois lfsr, one step per bit taken, lsb out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r = {r[30:0], lfsr_state[0]};
      lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
    end
    return r;
  endfunction

  // memory write, model merges only the strobed bytes
  task automatic write_word(input dm_word_addr_t w, input dm_data_t d, input logic [3:0] strb,
                            input int dly);
    dm_resp_t r;
    axil_write(dm_bus_addr_t'({w, 2'b00}), d, strb, dly, r);
    check_resp("s_bresp", resp_okay, r);
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model[w][b*8 +: 8] = d[b*8 +: 8];
      end
    end
    exp_wr++;
  endtask

  // memory read checked against the model
  task automatic read_word(input dm_word_addr_t w, input int dly);
    dm_resp_t r;
    dm_data_t v;
    axil_read(dm_bus_addr_t'({w, 2'b00}), dly, r, v);
    check_resp("s_rresp", resp_okay, r);
    check_data("s_rdata", model[w], v);
    exp_rd++;
  endtask

  task automatic reg_read(input dm_bus_addr_t a, output dm_data_t v);
    dm_resp_t r;
    axil_read(a, 0, r, v);
    check_resp("s_rresp", resp_okay, r);
  endtask

  task automatic check_counters();
    dm_data_t v;
    reg_read(rdcnt_addr, v);
    check_data("rdcnt", dm_data_t'(exp_rd), v);
    reg_read(wrcnt_addr, v);
    check_data("wrcnt", dm_data_t'(exp_wr), v);
  endtask

  // read status until bit 0 matches want
  task automatic poll_status(input logic want);
    dm_data_t v;
    bit done;
    done = 1'b0;
    for (int n = 0; n < poll_limit && !done; n++) begin
      reg_read(status_addr, v);
      done = (v[0] === want);
    end
    if (!done) begin
      timeout_count++;
      $display("timeout at %0t: status bit 0 never became %0b", $time, want);
    end
  endtask

  // sweep after reset leaves all zero
  task automatic test_after_reset();
    poll_status(1'b0);
    for (int i = 0; i < 8; i++) begin
      read_word(dm_word_addr_t'(rand_bits(12)), 0);
    end
    check_counters();
  endtask

  // full words, then partial strobes on the same words
  task automatic test_write_read();
    for (int i = 0; i < 16; i++) begin
      used[i] = dm_word_addr_t'(rand_bits(12));
      write_word(used[i], rand_bits(32), 4'hf, 0);
    end
    for (int i = 0; i < 16; i++) begin
      read_word(used[i], 0);
    end
    for (int i = 0; i < 8; i++) begin
      write_word(used[i], rand_bits(32), 4'(rand_bits(4)), 0);
      read_word(used[i], 0);
    end
  endtask

  // random mix with slow bready and rready
  task automatic test_backpressure();
    dm_word_addr_t w;
    for (int i = 0; i < 24; i++) begin
      w = rand_bits(1) ? used[rand_bits(4)] : dm_word_addr_t'(rand_bits(12));
      if (rand_bits(1)) begin
        write_word(w, rand_bits(32), 4'hf, int'(rand_bits(2)));
      end else begin
        read_word(w, int'(rand_bits(2)));
      end
    end
    check_counters();
  endtask

  // software clear through ctrl bit 0
  task automatic test_clear();
    dm_data_t v;
    dm_resp_t r;
    axil_write(ctrl_addr, 32'h1, 4'hf, 0, r);
    check_resp("s_bresp", resp_okay, r);
    poll_status(1'b1);
    poll_status(1'b0);
    for (int i = 0; i < mem_words; i++) begin
      model[i] = '0;
    end
    for (int i = 0; i < 16; i++) begin
      read_word(used[i], 0);
    end
    reg_read(ctrl_addr, v);
    check_data("ctrl", '0, v);
  endtask

  // unmapped accesses, then counter reset by write
  task automatic test_bad_address();
    dm_data_t v;
    dm_resp_t r;
    // reg_base+16 carries word index 4 in its low bits
    write_word(dm_word_addr_t'(4), rand_bits(32), 4'hf, 0);
    check_counters();
    axil_write(dm_bus_addr_t'(reg_base + 16), rand_bits(32), 4'hf, 0, r);
    check_resp("s_bresp", resp_slverr, r);
    axil_read(15'h7ffc, 0, r, v);
    check_resp("s_rresp", resp_slverr, r);
    check_data("s_rdata", '0, v);
    check_counters();
    read_word(dm_word_addr_t'(4), 0);
    axil_write(rdcnt_addr, rand_bits(32), 4'hf, 0, r);
    check_resp("s_bresp", resp_okay, r);
    axil_write(wrcnt_addr, rand_bits(32), 4'hf, 0, r);
    check_resp("s_bresp", resp_okay, r);
    exp_rd = 0;
    exp_wr = 0;
    check_counters();
  endtask

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst           = 1'b1;
    s_awaddr      = '0;
    s_awvalid     = 1'b0;
    s_wdata       = '0;
    s_wstrb       = '0;
    s_wvalid      = 1'b0;
    s_bready      = 1'b0;
    s_araddr      = '0;
    s_arvalid     = 1'b0;
    s_rready      = 1'b0;
    error_count   = 0;
    timeout_count = 0;
    exp_rd        = 0;
    exp_wr        = 0;
    lfsr_state    = 32'he553_00be;
    for (int i = 0; i < mem_words; i++) begin
      model[i] = '0;
    end
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    test_after_reset();
    test_write_read();
    test_backpressure();
    test_clear();
    test_bad_address();
    $display("errors: %0d value, %0d timeout", error_count, timeout_count);
    if (error_count == 0 && timeout_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- dm_subsystem.f
+incdir+include
rtl/dm_pkg.sv
rtl/dm_store.sv
rtl/dm_regs.sv
rtl/dm_axil_slave.sv
rtl/dm_subsystem.sv
test/dm_subsystem_tb.sv
